// ==== rtl/alu_unit.sv ====
`timescale 1ns/10ps

module alu_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   alu_valid,
    input  backend_pkg::exec_pkt_t exec,
    output logic                   wb_valid,
    output backend_pkg::wb_pkt_t   wb
);

    isa_pkg::word_t a;
    isa_pkg::word_t b;
    logic [4:0]     shamt;
    isa_pkg::word_t result;

    assign a     = exec.src1;
    assign b     = exec.src2;
    assign shamt = b[4:0];

    always_comb begin
        case (exec.op)
            isa_pkg::op_add: begin
                result = a + b;
            end
            isa_pkg::op_sub: begin
                result = a - b;
            end
            isa_pkg::op_and: begin
                result = a & b;
            end
            isa_pkg::op_or: begin
                result = a | b;
            end
            isa_pkg::op_xor: begin
                result = a ^ b;
            end
            isa_pkg::op_sll: begin
                result = a << shamt;
            end
            isa_pkg::op_srl: begin
                result = a >> shamt;
            end
            isa_pkg::op_sra: begin
                result = isa_pkg::word_t'($signed(a) >>> shamt);
            end
            isa_pkg::op_slt: begin
                result = {31'b0, $signed(a) < $signed(b)};
            end
            isa_pkg::op_sltu: begin
                result = {31'b0, a < b};
            end
            isa_pkg::op_li: begin
                result = exec.imm;
            end
            // multiply ops are routed elsewhere
            default: begin
                result = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= alu_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb.rd      <= exec.rd;
        wb.arch_rd <= exec.arch_rd;
        wb.value   <= result;
    end

endmodule

// ==== rtl/backend_pkg.sv ====
package backend_pkg;

    // 64 physical registers, tag zero never holds a live value
    localparam int PHYS_REG_BITS = 6;

    typedef logic [PHYS_REG_BITS-1:0] phys_reg_t;

    typedef struct packed {
        isa_pkg::fu_op_t   op;
        phys_reg_t         rd;
        phys_reg_t         rs1;
        phys_reg_t         rs2;
        isa_pkg::arch_reg_t arch_rd;
        isa_pkg::arch_reg_t arch_s1;
        isa_pkg::arch_reg_t arch_s2;
        isa_pkg::word_t    imm;
    } issue_pkt_t;

    typedef struct packed {
        isa_pkg::fu_op_t   op;
        phys_reg_t         rd;
        isa_pkg::arch_reg_t arch_rd;
        isa_pkg::word_t    src1;
        isa_pkg::word_t    src2;
        isa_pkg::word_t    imm;
    } exec_pkt_t;

    typedef struct packed {
        phys_reg_t         rd;
        isa_pkg::arch_reg_t arch_rd;
        isa_pkg::word_t    value;
    } wb_pkt_t;

    typedef enum logic {
        unit_alu,
        unit_mul
    } fu_unit_t;

    function automatic fu_unit_t unit_of(isa_pkg::fu_op_t op);
        case (op)
            isa_pkg::op_mul, isa_pkg::op_mulh, isa_pkg::op_mulhsu, isa_pkg::op_mulhu:
                return unit_mul;
            default:
                return unit_alu;
        endcase
    endfunction

    function automatic logic is_mul_op(isa_pkg::fu_op_t op);
        return unit_of(op) == unit_mul;
    endfunction

endpackage

// ==== rtl/exec_backend.sv ====
`timescale 1ns/10ps

module exec_backend #(
    parameter int MUL_STAGES = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_valid,
    input  backend_pkg::issue_pkt_t issue,
    output logic                    issue_ready,
    output logic                    wb_alu_valid,
    output backend_pkg::wb_pkt_t    wb_alu,
    output logic                    wb_mul_valid,
    output backend_pkg::wb_pkt_t    wb_mul
);

    backend_pkg::phys_reg_t src1_tag;
    backend_pkg::phys_reg_t src2_tag;
    isa_pkg::arch_reg_t     src_arch1;
    isa_pkg::arch_reg_t     src_arch2;
    isa_pkg::word_t         src1_value;
    isa_pkg::word_t         src2_value;
    logic                   alu_valid;
    logic                   mul_valid;
    backend_pkg::exec_pkt_t exec;

    issue_router issue_router_i (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_ready  (issue_ready),
        .src1_tag     (src1_tag),
        .src2_tag     (src2_tag),
        .src_arch1    (src_arch1),
        .src_arch2    (src_arch2),
        .src1_value   (src1_value),
        .src2_value   (src2_value),
        .alu_valid    (alu_valid),
        .mul_valid    (mul_valid),
        .exec         (exec),
        .wb_alu_valid (wb_alu_valid),
        .wb_mul_valid (wb_mul_valid),
        .wb_alu_rd    (wb_alu.rd),
        .wb_mul_rd    (wb_mul.rd)
    );

    phys_regfile phys_regfile_i (
        .clk       (clk),
        .rst       (rst),
        .we_alu    (wb_alu_valid),
        .we_mul    (wb_mul_valid),
        .wb_alu    (wb_alu),
        .wb_mul    (wb_mul),
        .rs1_tag   (src1_tag),
        .rs2_tag   (src2_tag),
        .arch_s1   (src_arch1),
        .arch_s2   (src_arch2),
        .rs1_value (src1_value),
        .rs2_value (src2_value)
    );

    alu_unit alu_unit_i (
        .clk       (clk),
        .rst       (rst),
        .alu_valid (alu_valid),
        .exec      (exec),
        .wb_valid  (wb_alu_valid),
        .wb        (wb_alu)
    );

    mul_unit #(
        .MUL_STAGES (MUL_STAGES)
    ) mul_unit_i (
        .clk       (clk),
        .rst       (rst),
        .mul_valid (mul_valid),
        .exec      (exec),
        .wb_valid  (wb_mul_valid),
        .wb        (wb_mul)
    );

endmodule

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

    localparam int WORD_BITS = 32;
    localparam int ARCH_REG_BITS = 5;

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [ARCH_REG_BITS-1:0] arch_reg_t;

    // x0 is hardwired to zero
    localparam arch_reg_t X0 = '0;

    typedef enum logic [3:0] {
        // single-cycle integer group
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu,
        op_li,
        // multiply group
        op_mul,
        op_mulh,
        op_mulhsu,
        op_mulhu
    } fu_op_t;

endpackage

// ==== rtl/issue_router.sv ====
`timescale 1ns/10ps

module issue_router (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_valid,
    input  backend_pkg::issue_pkt_t issue,
    output logic                   issue_ready,
    output backend_pkg::phys_reg_t src1_tag,
    output backend_pkg::phys_reg_t src2_tag,
    output isa_pkg::arch_reg_t     src_arch1,
    output isa_pkg::arch_reg_t     src_arch2,
    input  isa_pkg::word_t         src1_value,
    input  isa_pkg::word_t         src2_value,
    output logic                   alu_valid,
    output logic                   mul_valid,
    output backend_pkg::exec_pkt_t exec,
    input  logic                   wb_alu_valid,
    input  logic                   wb_mul_valid,
    input  backend_pkg::phys_reg_t wb_alu_rd,
    input  backend_pkg::phys_reg_t wb_mul_rd
);

    localparam int NUM_REGS = 2 ** backend_pkg::PHYS_REG_BITS;

    logic [NUM_REGS-1:0] busy;
    logic [NUM_REGS-1:0] wb_clear;
    logic [NUM_REGS-1:0] busy_eff;
    logic                accept;
    logic                to_mul;

    // writebacks this cycle already count as free, the regfile bypasses them
    always_comb begin
        wb_clear = '0;
        if (wb_alu_valid) begin
            wb_clear[wb_alu_rd] = 1'b1;
        end
        if (wb_mul_valid) begin
            wb_clear[wb_mul_rd] = 1'b1;
        end
        busy_eff = busy & ~wb_clear;
        busy_eff[0] = 1'b0;
    end

    // rd is checked too so a second writer waits for the first
    assign issue_ready = !rst
                      && !busy_eff[issue.rs1]
                      && !busy_eff[issue.rs2]
                      && !busy_eff[issue.rd];

    assign accept = issue_valid && issue_ready;
    assign to_mul = backend_pkg::is_mul_op(issue.op);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            busy <= busy & ~wb_clear;
            if (accept && (issue.rd != '0)) begin
                busy[issue.rd] <= 1'b1;
            end
        end
    end

    // operand lookup straight from the packet
    assign src1_tag  = issue.rs1;
    assign src2_tag  = issue.rs2;
    assign src_arch1 = issue.arch_s1;
    assign src_arch2 = issue.arch_s2;

    always_comb begin
        exec.op      = issue.op;
        exec.rd      = issue.rd;
        exec.arch_rd = issue.arch_rd;
        exec.src1    = src1_value;
        exec.src2    = src2_value;
        exec.imm     = issue.imm;
    end

    assign alu_valid = accept && !to_mul;
    assign mul_valid = accept && to_mul;

endmodule

// ==== rtl/mul_unit.sv ====
`timescale 1ns/10ps

module mul_unit #(
    parameter int MUL_STAGES = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mul_valid,
    input  backend_pkg::exec_pkt_t exec,
    output logic                   wb_valid,
    output backend_pkg::wb_pkt_t   wb
);

    typedef struct packed {
        backend_pkg::phys_reg_t rd;
        isa_pkg::arch_reg_t     arch_rd;
        logic                   take_hi;
        logic [63:0]            product;
    } mul_stage_t;

    logic                  sign_a;
    logic                  sign_b;
    logic signed [32:0]    a_ext;
    logic signed [32:0]    b_ext;
    logic signed [65:0]    full_product;
    mul_stage_t            stage_in;
    mul_stage_t            stage_q [MUL_STAGES];
    logic [MUL_STAGES-1:0] valid_q;

    // mulh is signed x signed, mulhsu signed x unsigned
    assign sign_a = (exec.op == isa_pkg::op_mulh) || (exec.op == isa_pkg::op_mulhsu);
    assign sign_b = (exec.op == isa_pkg::op_mulh);

    always_comb begin
        a_ext = {sign_a && exec.src1[31], exec.src1};
        b_ext = {sign_b && exec.src2[31], exec.src2};
        full_product = a_ext * b_ext;

        stage_in.rd      = exec.rd;
        stage_in.arch_rd = exec.arch_rd;
        stage_in.take_hi = (exec.op != isa_pkg::op_mul);
        stage_in.product = full_product[63:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= mul_valid;
            for (int s = 1; s < MUL_STAGES; s++) begin
                valid_q[s] <= valid_q[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        stage_q[0] <= stage_in;
        for (int s = 1; s < MUL_STAGES; s++) begin
            stage_q[s] <= stage_q[s-1];
        end
    end

    // low word for mul, high word for the rest
    always_comb begin
        wb_valid   = valid_q[MUL_STAGES-1];
        wb.rd      = stage_q[MUL_STAGES-1].rd;
        wb.arch_rd = stage_q[MUL_STAGES-1].arch_rd;
        wb.value   = stage_q[MUL_STAGES-1].take_hi ? stage_q[MUL_STAGES-1].product[63:32]
                                                   : stage_q[MUL_STAGES-1].product[31:0];
    end

endmodule

// ==== rtl/phys_regfile.sv ====
`timescale 1ns/10ps

module phys_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we_alu,
    input  logic                  we_mul,
    input  backend_pkg::wb_pkt_t  wb_alu,
    input  backend_pkg::wb_pkt_t  wb_mul,
    input  backend_pkg::phys_reg_t rs1_tag,
    input  backend_pkg::phys_reg_t rs2_tag,
    input  isa_pkg::arch_reg_t    arch_s1,
    input  isa_pkg::arch_reg_t    arch_s2,
    output isa_pkg::word_t        rs1_value,
    output isa_pkg::word_t        rs2_value
);

    localparam int NUM_REGS = 2 ** backend_pkg::PHYS_REG_BITS;

    isa_pkg::word_t data [NUM_REGS];

    logic           alu_write;
    logic           mul_write;
    isa_pkg::word_t alu_wdata;
    isa_pkg::word_t mul_wdata;

    // tag zero is dropped, x0 destinations store zero
    always_comb begin
        alu_write = we_alu && (wb_alu.rd != '0);
        mul_write = we_mul && (wb_mul.rd != '0);
        alu_wdata = (wb_alu.arch_rd == isa_pkg::X0) ? '0 : wb_alu.value;
        mul_wdata = (wb_mul.arch_rd == isa_pkg::X0) ? '0 : wb_mul.value;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                data[i] <= '0;
            end
        end else begin
            if (alu_write) begin
                data[wb_alu.rd] <= alu_wdata;
            end
            if (mul_write) begin
                data[wb_mul.rd] <= mul_wdata;
            end
        end
    end

    function automatic isa_pkg::word_t read_port(
        backend_pkg::phys_reg_t tag,
        isa_pkg::arch_reg_t     arch
    );
        isa_pkg::word_t value;
        if (arch == isa_pkg::X0) begin
            value = '0;
        end else if (mul_write && (wb_mul.rd == tag)) begin
            value = mul_wdata;
        end else if (alu_write && (wb_alu.rd == tag)) begin
            value = alu_wdata;
        end else begin
            value = data[tag];
        end
        return value;
    endfunction

    // reads see writebacks of the same cycle
    always_comb begin
        rs1_value = read_port(rs1_tag, arch_s1);
        rs2_value = read_port(rs2_tag, arch_s2);
    end

endmodule

// ==== sim.f ====
rtl/isa_pkg.sv
rtl/backend_pkg.sv
rtl/phys_regfile.sv
rtl/issue_router.sv
rtl/alu_unit.sv
rtl/mul_unit.sv
rtl/exec_backend.sv
sim/exec_backend_assert.sv
sim/exec_backend_tb.sv

// ==== sim/exec_backend_assert.sv ====
`timescale 1ns/10ps

module exec_backend_assert #(
    parameter int MUL_STAGES = 4
) (
    input logic                    clk,
    input logic                    rst,
    input logic                    issue_valid,
    input logic                    issue_ready,
    input backend_pkg::issue_pkt_t issue,
    input logic                    wb_alu_valid,
    input logic                    wb_mul_valid,
    input backend_pkg::wb_pkt_t    wb_alu,
    input backend_pkg::wb_pkt_t    wb_mul
);

    int   fails = 0;
    logic accept_alu;
    logic accept_mul;

    assign accept_alu = issue_valid && issue_ready && !backend_pkg::is_mul_op(issue.op);
    assign accept_mul = issue_valid && issue_ready && backend_pkg::is_mul_op(issue.op);

    ready_in_reset: assert property (@(posedge clk) rst |-> !issue_ready)
        else begin fails++; $error("issue_ready high during reset"); end

    alu_latency: assert property (@(posedge clk) disable iff (rst) accept_alu |=> wb_alu_valid)
        else begin fails++; $error("ALU writeback missing one cycle after issue"); end

    // one writeback per accepted multiply, MUL_STAGES edges later
    mul_latency: assert property (
        @(posedge clk) disable iff (rst) accept_mul |-> ##MUL_STAGES wb_mul_valid)
        else begin fails++; $error("multiply writeback missing after MUL_STAGES cycles"); end

    wb_tag_clash: assert property (@(posedge clk) disable iff (rst)
        !(wb_alu_valid && wb_mul_valid && (wb_alu.rd == wb_mul.rd) && (wb_alu.rd != '0)))
        else begin fails++; $error("both writebacks target the same physical tag"); end

endmodule

bind exec_backend exec_backend_assert #(
    .MUL_STAGES (MUL_STAGES)
) exec_backend_assert_i (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .issue_ready  (issue_ready),
    .issue        (issue),
    .wb_alu_valid (wb_alu_valid),
    .wb_mul_valid (wb_mul_valid),
    .wb_alu       (wb_alu),
    .wb_mul       (wb_mul)
);

// ==== sim/exec_backend_tb.sv ====
`timescale 1ns/10ps

module exec_backend_tb;

    localparam int MUL_STAGES = 4;
    localparam int TIMEOUT = 100;

    logic                    clk;
    logic                    rst;
    logic                    issue_valid;
    backend_pkg::issue_pkt_t issue;
    logic                    issue_ready;
    logic                    wb_alu_valid;
    logic                    wb_mul_valid;
    backend_pkg::wb_pkt_t    wb_alu;
    backend_pkg::wb_pkt_t    wb_mul;

    isa_pkg::word_t       model [64];
    backend_pkg::wb_pkt_t alu_q[$];
    backend_pkg::wb_pkt_t mul_q[$];
    string                test_name = "reset";
    int                   seed = 12;
    int                   cycle = 0;
    int                   tests = 0;
    int                   checks = 0;
    int                   errors = 0;
    int                   err_start = 0;

    exec_backend #(
        .MUL_STAGES (MUL_STAGES)
    ) exec_backend_i (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_ready  (issue_ready),
        .wb_alu_valid (wb_alu_valid),
        .wb_alu       (wb_alu),
        .wb_mul_valid (wb_mul_valid),
        .wb_mul       (wb_mul)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // RV32I and M extension results
    function automatic isa_pkg::word_t ref_result(isa_pkg::fu_op_t op, isa_pkg::word_t a,
                                                  isa_pkg::word_t b, isa_pkg::word_t imm);
        logic [63:0] p_ss;
        logic [63:0] p_su;
        logic [63:0] p_uu;
        p_ss = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        p_su = {{32{a[31]}}, a} * {32'b0, b};
        p_uu = {32'b0, a} * {32'b0, b};
        case (op)
            isa_pkg::op_add:    return a + b;
            isa_pkg::op_sub:    return a - b;
            isa_pkg::op_and:    return a & b;
            isa_pkg::op_or:     return a | b;
            isa_pkg::op_xor:    return a ^ b;
            isa_pkg::op_sll:    return a << b[4:0];
            isa_pkg::op_srl:    return a >> b[4:0];
            isa_pkg::op_sra:    return $signed(a) >>> b[4:0];
            isa_pkg::op_slt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            isa_pkg::op_sltu:   return (a < b) ? 32'd1 : 32'd0;
            isa_pkg::op_li:     return imm;
            isa_pkg::op_mul:    return p_uu[31:0];
            isa_pkg::op_mulh:   return p_ss[63:32];
            isa_pkg::op_mulhsu: return p_su[63:32];
            default:            return p_uu[63:32];
        endcase
    endfunction

    function automatic backend_pkg::issue_pkt_t make_pkt(isa_pkg::fu_op_t op, int rd, int rs1,
            int rs2, int ard, int as1, int as2, isa_pkg::word_t imm);
        backend_pkg::issue_pkt_t pkt;
        pkt.op      = op;
        pkt.rd      = backend_pkg::phys_reg_t'(rd);
        pkt.rs1     = backend_pkg::phys_reg_t'(rs1);
        pkt.rs2     = backend_pkg::phys_reg_t'(rs2);
        pkt.arch_rd = isa_pkg::arch_reg_t'(ard);
        pkt.arch_s1 = isa_pkg::arch_reg_t'(as1);
        pkt.arch_s2 = isa_pkg::arch_reg_t'(as2);
        pkt.imm     = imm;
        return pkt;
    endfunction

    task automatic report_timeout(input string why);
        errors++;
        $display("%s: %s", test_name, why);
    endtask

    task automatic expect_int(input string what, input int exp, input int act);
        checks++;
        assert (exp == act) else begin
            errors++;
            $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_wb(input string unit, input backend_pkg::wb_pkt_t exp,
                            input backend_pkg::wb_pkt_t act);
        checks++;
        assert (exp == act) else begin
            errors++;
            $display("[ERROR] %s %s writeback: expected %h, actual %h",
                     test_name, unit, exp, act);
        end
    endtask

    always @(posedge clk) begin
        if (!rst && wb_alu_valid) begin
            assert (alu_q.size() != 0) else begin
                errors++;
                $display("%s: ALU writeback arrived with nothing outstanding", test_name);
            end
            if (alu_q.size() != 0) begin
                check_wb("alu", alu_q.pop_front(), wb_alu);
            end
        end
        if (!rst && wb_mul_valid) begin
            assert (mul_q.size() != 0) else begin
                errors++;
                $display("%s: multiply writeback arrived with nothing outstanding", test_name);
            end
            if (mul_q.size() != 0) begin
                check_wb("mul", mul_q.pop_front(), wb_mul);
            end
        end
    end

    // holds the packet until accepted, then updates the reference model
    task automatic issue_op(input backend_pkg::issue_pkt_t pkt, output int acc_cycle);
        int                   waited;
        isa_pkg::word_t       a;
        isa_pkg::word_t       b;
        backend_pkg::wb_pkt_t exp;
        @(negedge clk);
        issue_valid = 1'b1;
        issue = pkt;
        waited = 0;
        @(posedge clk);
        while (!issue_ready && waited < TIMEOUT) begin
            waited++;
            @(posedge clk);
        end
        if (!issue_ready) begin
            report_timeout("issue_ready stayed low too long");
        end else begin
            acc_cycle = cycle;
            a = (pkt.arch_s1 == isa_pkg::X0) ? '0 : model[pkt.rs1];
            b = (pkt.arch_s2 == isa_pkg::X0) ? '0 : model[pkt.rs2];
            exp = '{pkt.rd, pkt.arch_rd, ref_result(pkt.op, a, b, pkt.imm)};
            if (backend_pkg::is_mul_op(pkt.op)) begin
                mul_q.push_back(exp);
            end else begin
                alu_q.push_back(exp);
            end
            if (pkt.rd != '0) begin
                model[pkt.rd] = (pkt.arch_rd == isa_pkg::X0) ? '0 : exp.value;
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic end_test();
        int waited;
        waited = 0;
        @(negedge clk);
        issue_valid = 1'b0;
        while ((alu_q.size() != 0 || mul_q.size() != 0) && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (alu_q.size() != 0 || mul_q.size() != 0) begin
            report_timeout("expected writebacks never arrived");
            alu_q.delete();
            mul_q.delete();
        end
        tests++;
        $display("%s done, %0d errors", test_name, errors - err_start);
    endtask

    initial begin
        int                      c0;
        int                      c1;
        int                      prev;
        int                      gap;
        int                      total;
        backend_pkg::issue_pkt_t pkt;
        rst = 1'b1;
        issue_valid = 1'b0;
        issue = '0;
        for (int i = 0; i < 64; i++) begin
            model[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("alu_ops");
        for (int i = 1; i <= 6; i++) begin
            issue_op(make_pkt(isa_pkg::op_li, i, 0, 0, i, 0, 0, $random(seed)), c0);
        end
        for (int k = 0; k < 30; k++) begin
            pkt = make_pkt(isa_pkg::fu_op_t'(k / 3), 20 + k % 16, 1 + k % 3, 6 - k % 3,
                           10, 1 + k % 3, 6 - k % 3, 0);
            issue_op(pkt, c0);
        end
        end_test();

        start_test("zero_rules");
        issue_op(make_pkt(isa_pkg::op_li, 30, 0, 0, 0, 0, 0, 32'hdead_beef), c0);
        issue_op(make_pkt(isa_pkg::op_add, 31, 30, 0, 5, 3, 0, 0), c0);
        issue_op(make_pkt(isa_pkg::op_add, 32, 1, 2, 6, 0, 4, 0), c0);
        issue_op(make_pkt(isa_pkg::op_li, 0, 0, 0, 7, 0, 0, 32'h0000_1234), c0);
        issue_op(make_pkt(isa_pkg::op_or, 33, 0, 3, 8, 7, 3, 0), c0);
        end_test();

        start_test("mul_burst");
        for (int i = 0; i < 16; i++) begin
            pkt = make_pkt(isa_pkg::fu_op_t'(int'(isa_pkg::op_mul) + i / 4), 40 + i,
                           1 + i % 4, 2 + i % 4, 9, 1, 2, 0);
            issue_op(pkt, c0);
            if (i > 0) begin
                expect_int("accept cycle", prev + 1, c0);
            end
            prev = c0;
        end
        end_test();

        start_test("dependence");
        issue_op(make_pkt(isa_pkg::op_mul, 50, 1, 2, 11, 1, 2, 0), c0);
        issue_op(make_pkt(isa_pkg::op_add, 51, 50, 3, 12, 11, 3, 0), c1);
        expect_int("raw accept cycle", c0 + MUL_STAGES, c1);
        issue_op(make_pkt(isa_pkg::op_mulhu, 52, 3, 4, 13, 3, 4, 0), c0);
        issue_op(make_pkt(isa_pkg::op_li, 52, 0, 0, 14, 0, 0, 32'h5a5a_0001), c1);
        expect_int("waw accept cycle", c0 + MUL_STAGES, c1);
        end_test();

        start_test("random_mix");
        for (int i = 0; i < 200; i++) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(negedge clk) issue_valid = 1'b0;
            pkt.op = isa_pkg::fu_op_t'($unsigned($random(seed)) % 15);
            pkt.rd = backend_pkg::phys_reg_t'(1 + $unsigned($random(seed)) % 63);
            pkt.rs1 = backend_pkg::phys_reg_t'(1 + $unsigned($random(seed)) % 63);
            pkt.rs2 = backend_pkg::phys_reg_t'(1 + $unsigned($random(seed)) % 63);
            pkt.arch_rd = isa_pkg::arch_reg_t'($random(seed));
            pkt.arch_s1 = isa_pkg::arch_reg_t'($random(seed));
            pkt.arch_s2 = isa_pkg::arch_reg_t'($random(seed));
            pkt.imm = $random(seed);
            issue_op(pkt, c0);
        end
        end_test();

        total = errors + exec_backend_i.exec_backend_assert_i.fails;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, total);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
